/* tcdm_pkg.sv */
`default_nettype none

package tcdm_pkg;

  // cluster geometry
  localparam int unsigned NumIn          = 4;   // initiator ports
  localparam int unsigned NumBanks       = 4;   // tcdm banks
  localparam int unsigned AddrWidth      = 32;  // initiator byte address
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned BeWidth        = DataWidth / 8;
  localparam int unsigned ByteOffWidth   = 2;   // byte inside a word
  localparam int unsigned BankSelWidth   = 2;   // word-interleaved bank select
  localparam int unsigned BankAddrWidth  = 8;   // word inside a bank
  localparam int unsigned BankWords      = 2 ** BankAddrWidth;
  localparam int unsigned IdxWidth       = 2;   // initiator index carried with a request
  localparam int unsigned NumOutstanding = 2;   // in-flight transactions per bank

  // target queue sizing
  localparam int unsigned PtrWidth = (NumOutstanding > 1) ? $clog2(NumOutstanding) : 1;
  localparam int unsigned CntWidth = $clog2(NumOutstanding + 1);  // must reach NumOutstanding

  // request as issued by an initiator
  typedef struct packed {
    logic                 wen;    // 1: store, 0: load
    logic [BeWidth-1:0]   be;
    logic [AddrWidth-1:0] addr;   // byte address
    logic [DataWidth-1:0] wdata;
  } tcdm_req_t;

  // request as a bank sees it
  typedef struct packed {
    logic                     wen;
    logic [BeWidth-1:0]       be;
    logic [BankAddrWidth-1:0] addr;  // word address inside the bank
    logic [DataWidth-1:0]     wdata;
    logic [IdxWidth-1:0]      idx;   // who asked, echoed back by the bank
  } bank_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;  // undefined for stores
    logic [IdxWidth-1:0]  idx;
  } bank_rsp_t;

endpackage

`default_nettype wire

/* tcdm_xbar.sv */
`default_nettype none

module tcdm_xbar (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  // initiator side
  input  logic [tcdm_pkg::NumIn-1:0]                              req_i,
  input  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::BankSelWidth-1:0]  bank_sel_i,
  input  tcdm_pkg::bank_req_t [tcdm_pkg::NumIn-1:0]               wdata_i,  // idx left empty
  output logic [tcdm_pkg::NumIn-1:0]                              gnt_o,
  // bank side
  output logic [tcdm_pkg::NumBanks-1:0]                           bank_req_o,
  output tcdm_pkg::bank_req_t [tcdm_pkg::NumBanks-1:0]            bank_wdata_o,
  input  logic [tcdm_pkg::NumBanks-1:0]                           bank_ready_i,  // queue not full
  // response side, queue heads
  input  logic [tcdm_pkg::NumBanks-1:0]                           rsp_vld_i,
  input  tcdm_pkg::bank_rsp_t [tcdm_pkg::NumBanks-1:0]            rsp_i,
  output logic [tcdm_pkg::NumBanks-1:0]                           rsp_pop_o,
  output logic [tcdm_pkg::NumIn-1:0]                              vld_o,
  output logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::DataWidth-1:0]     rdata_o,
  input  logic [tcdm_pkg::NumIn-1:0]                              rdy_i
);

  logic [tcdm_pkg::NumBanks-1:0][tcdm_pkg::IdxWidth-1:0]   req_rr_q, req_rr_d;  // per bank
  logic [tcdm_pkg::NumBanks-1:0][tcdm_pkg::IdxWidth-1:0]   req_win;
  logic [tcdm_pkg::NumBanks-1:0]                           req_any;
  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::BankSelWidth-1:0]  rsp_rr_q, rsp_rr_d;  // per initiator
  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::BankSelWidth-1:0]  rsp_win;

  // request arbitration, one rr arbiter per bank
  always_comb begin : req_arb
    logic [tcdm_pkg::IdxWidth-1:0] cand;
    for (int b = 0; b < tcdm_pkg::NumBanks; b++) begin
      req_any[b] = 1'b0;
      req_win[b] = req_rr_q[b];
      // walk backwards so the initiator closest to the pointer is kept last
      for (int off = tcdm_pkg::NumIn - 1; off >= 0; off--) begin
        cand = req_rr_q[b] + tcdm_pkg::IdxWidth'(off);  // wraps, NumIn is 2**IdxWidth
        if (req_i[cand] && (bank_sel_i[cand] == tcdm_pkg::BankSelWidth'(b))) begin
          req_any[b] = 1'b1;
          req_win[b] = cand;
        end
      end
      bank_req_o[b]       = req_any[b] & bank_ready_i[b];  // full queue blocks the bank
      bank_wdata_o[b]     = wdata_i[req_win[b]];
      bank_wdata_o[b].idx = req_win[b];                    // tag for the way back
      req_rr_d[b]         = bank_req_o[b] ? req_win[b] + 1'b1 : req_rr_q[b];
    end
    for (int i = 0; i < tcdm_pkg::NumIn; i++) begin
      gnt_o[i] = req_i[i] & bank_req_o[bank_sel_i[i]]
               & (req_win[bank_sel_i[i]] == tcdm_pkg::IdxWidth'(i));
    end
  end

  // response arbitration, one rr arbiter per initiator over the queue heads
  always_comb begin : rsp_arb
    logic [tcdm_pkg::BankSelWidth-1:0] cand;
    rsp_pop_o = '0;
    for (int i = 0; i < tcdm_pkg::NumIn; i++) begin
      vld_o[i]   = 1'b0;
      rsp_win[i] = rsp_rr_q[i];
      for (int off = tcdm_pkg::NumBanks - 1; off >= 0; off--) begin
        cand = rsp_rr_q[i] + tcdm_pkg::BankSelWidth'(off);
        if (rsp_vld_i[cand] && (rsp_i[cand].idx == tcdm_pkg::IdxWidth'(i))) begin
          vld_o[i]   = 1'b1;
          rsp_win[i] = cand;
        end
      end
      rdata_o[i] = rsp_i[rsp_win[i]].rdata;
      if (vld_o[i] && rdy_i[i]) begin
        rsp_pop_o[rsp_win[i]] = 1'b1;
        rsp_rr_d[i]           = rsp_win[i] + 1'b1;  // move past the bank just served
      end else if (vld_o[i]) begin
        rsp_rr_d[i] = rsp_win[i];  // stalled, park on the winner so the head stays put
      end else begin
        rsp_rr_d[i] = rsp_rr_q[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_rr_q <= '0;
      rsp_rr_q <= '0;
    end else begin
      req_rr_q <= req_rr_d;
      rsp_rr_q <= rsp_rr_d;
    end
  end

endmodule

`default_nettype wire

/* tcdm_target_queue.sv */
`default_nettype none

module tcdm_target_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                gnt_i,    // request taken by the bank
  input  logic                push_i,   // bank response valid
  input  tcdm_pkg::bank_rsp_t rsp_i,
  input  logic                pop_i,
  output logic                vld_o,    // head valid
  output tcdm_pkg::bank_rsp_t rsp_o,
  output logic                ready_o   // room for one more transaction
);

  tcdm_pkg::bank_rsp_t [tcdm_pkg::NumOutstanding-1:0] fifo_q;  // response storage
  logic [tcdm_pkg::PtrWidth-1:0]                      wr_ptr_q, rd_ptr_q;
  logic [tcdm_pkg::CntWidth-1:0]                      fill_q;   // entries in the fifo
  logic [tcdm_pkg::CntWidth-1:0]                      usage_q;  // granted, not yet retired
  logic                                               pop;
  logic                                               pop_q;

  assign pop     = pop_i & vld_o;
  assign vld_o   = (fill_q != '0);
  assign rsp_o   = fifo_q[rd_ptr_q];  // head shows through while not empty
  assign ready_o = (usage_q < tcdm_pkg::CntWidth'(tcdm_pkg::NumOutstanding));

  always_ff @(posedge clk_i) begin
    if (push_i) fifo_q[wr_ptr_q] <= rsp_i;  // never full here, usage_q gates the grants
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      usage_q  <= '0;
      pop_q    <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == tcdm_pkg::PtrWidth'(tcdm_pkg::NumOutstanding - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == tcdm_pkg::PtrWidth'(tcdm_pkg::NumOutstanding - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      fill_q  <= fill_q + tcdm_pkg::CntWidth'(push_i) - tcdm_pkg::CntWidth'(pop);
      // slot is freed a cycle after the pop
      usage_q <= usage_q + tcdm_pkg::CntWidth'(gnt_i) - tcdm_pkg::CntWidth'(pop_q);
      pop_q   <= pop;
    end
  end

endmodule

`default_nettype wire

/* tcdm_interconnect.sv */
`default_nettype none

module tcdm_interconnect (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  // initiator side
  input  logic [tcdm_pkg::NumIn-1:0]                            req_i,
  input  tcdm_pkg::tcdm_req_t [tcdm_pkg::NumIn-1:0]             tcdm_req_i,
  output logic [tcdm_pkg::NumIn-1:0]                            gnt_o,
  output logic [tcdm_pkg::NumIn-1:0]                            vld_o,
  output logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::DataWidth-1:0]   rdata_o,
  input  logic [tcdm_pkg::NumIn-1:0]                            rdy_i,
  // bank side, banks always grant
  output logic [tcdm_pkg::NumBanks-1:0]                         bank_req_o,
  output tcdm_pkg::bank_req_t [tcdm_pkg::NumBanks-1:0]          bank_wdata_o,
  input  logic [tcdm_pkg::NumBanks-1:0]                         bank_vld_i,
  input  tcdm_pkg::bank_rsp_t [tcdm_pkg::NumBanks-1:0]          bank_rsp_i
);

  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::BankSelWidth-1:0] bank_sel;
  tcdm_pkg::bank_req_t [tcdm_pkg::NumIn-1:0]              xbar_req;   // packed, no idx yet
  logic [tcdm_pkg::NumBanks-1:0]                          q_ready;
  logic [tcdm_pkg::NumBanks-1:0]                          q_vld;
  logic [tcdm_pkg::NumBanks-1:0]                          q_pop;
  tcdm_pkg::bank_rsp_t [tcdm_pkg::NumBanks-1:0]           q_rsp;

  // word interleaving: bank index right above the byte offset
  for (genvar i = 0; i < tcdm_pkg::NumIn; i++) begin : gen_decode
    assign bank_sel[i] = tcdm_req_i[i].addr[tcdm_pkg::ByteOffWidth +: tcdm_pkg::BankSelWidth];
    assign xbar_req[i] = '{
      wen:   tcdm_req_i[i].wen,
      be:    tcdm_req_i[i].be,
      addr:  tcdm_req_i[i].addr[tcdm_pkg::ByteOffWidth + tcdm_pkg::BankSelWidth +:
                                tcdm_pkg::BankAddrWidth],
      wdata: tcdm_req_i[i].wdata,
      idx:   '0  // filled in by the xbar
    };
  end

  tcdm_xbar u_xbar (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .bank_sel_i  (bank_sel),
    .wdata_i     (xbar_req),
    .gnt_o       (gnt_o),
    .bank_req_o  (bank_req_o),
    .bank_wdata_o(bank_wdata_o),
    .bank_ready_i(q_ready),
    .rsp_vld_i   (q_vld),
    .rsp_i       (q_rsp),
    .rsp_pop_o   (q_pop),
    .vld_o       (vld_o),
    .rdata_o     (rdata_o),
    .rdy_i       (rdy_i)
  );

  // one response queue per bank, stores answer too
  for (genvar b = 0; b < tcdm_pkg::NumBanks; b++) begin : gen_queues
    tcdm_target_queue u_queue (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .gnt_i  (bank_req_o[b]),
      .push_i (bank_vld_i[b]),
      .rsp_i  (bank_rsp_i[b]),
      .pop_i  (q_pop[b]),
      .vld_o  (q_vld[b]),
      .rsp_o  (q_rsp[b]),
      .ready_o(q_ready[b])
    );
  end

endmodule

`default_nettype wire

/* tcdm_bank.sv */
`default_nettype none

module tcdm_bank (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,       // always granted
  input  tcdm_pkg::bank_req_t req_data_i,
  output logic                vld_o,       // one cycle after every request
  output tcdm_pkg::bank_rsp_t rsp_o
);

  logic [tcdm_pkg::DataWidth-1:0] mem_q [tcdm_pkg::BankWords];  // single-ported array
  tcdm_pkg::bank_rsp_t            rsp_q;
  logic                           vld_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (req_data_i.wen) begin
        for (int unsigned j = 0; j < tcdm_pkg::BeWidth; j++) begin
          if (req_data_i.be[j]) mem_q[req_data_i.addr][8*j +: 8] <= req_data_i.wdata[8*j +: 8];
        end
      end
      rsp_q.rdata <= mem_q[req_data_i.addr];  // old word on a store, don't care
      rsp_q.idx   <= req_data_i.idx;          // echo the initiator back
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= req_i;  // loads and stores both answer
    end
  end

  assign vld_o = vld_q;
  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

/* tcdm_subsys.sv */
`default_nettype none

module tcdm_subsys (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic [tcdm_pkg::NumIn-1:0]                            req_i,
  input  tcdm_pkg::tcdm_req_t [tcdm_pkg::NumIn-1:0]             tcdm_req_i,
  output logic [tcdm_pkg::NumIn-1:0]                            gnt_o,
  output logic [tcdm_pkg::NumIn-1:0]                            vld_o,
  output logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::DataWidth-1:0]   rdata_o,
  input  logic [tcdm_pkg::NumIn-1:0]                            rdy_i
);

  logic [tcdm_pkg::NumBanks-1:0]                bank_req;
  tcdm_pkg::bank_req_t [tcdm_pkg::NumBanks-1:0] bank_wdata;
  logic [tcdm_pkg::NumBanks-1:0]                bank_vld;
  tcdm_pkg::bank_rsp_t [tcdm_pkg::NumBanks-1:0] bank_rsp;

  tcdm_interconnect u_interconnect (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .tcdm_req_i  (tcdm_req_i),
    .gnt_o       (gnt_o),
    .vld_o       (vld_o),
    .rdata_o     (rdata_o),
    .rdy_i       (rdy_i),
    .bank_req_o  (bank_req),
    .bank_wdata_o(bank_wdata),
    .bank_vld_i  (bank_vld),
    .bank_rsp_i  (bank_rsp)
  );

  for (genvar b = 0; b < tcdm_pkg::NumBanks; b++) begin : gen_banks
    tcdm_bank u_bank (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .req_i     (bank_req[b]),
      .req_data_i(bank_wdata[b]),
      .vld_o     (bank_vld[b]),
      .rsp_o     (bank_rsp[b])
    );
  end

endmodule

`default_nettype wire

/* tcdm_subsys_properties.sv */
`default_nettype none

module tcdm_subsys_properties (
  input logic                                                clk_i,
  input logic                                                rst_ni,
  input logic [tcdm_pkg::NumIn-1:0]                          req_i,
  input tcdm_pkg::tcdm_req_t [tcdm_pkg::NumIn-1:0]           tcdm_req_i,
  input logic [tcdm_pkg::NumIn-1:0]                          gnt_i,
  input logic [tcdm_pkg::NumIn-1:0]                          vld_i,
  input logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::DataWidth-1:0] rdata_i,
  input logic [tcdm_pkg::NumIn-1:0]                          rdy_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::BankSelWidth-1:0] sel, last_bank_q;
  logic [tcdm_pkg::NumBanks-1:0][tcdm_pkg::NumIn-1:0]     bank_gnt;   // grants, grouped by bank
  logic [tcdm_pkg::NumBanks-1:0][tcdm_pkg::NumIn-1:0]     busy_bank;  // who waits on which bank
  logic [tcdm_pkg::NumIn-1:0][1:0]                        inflight_q; // granted, not yet answered
  logic [tcdm_pkg::NumIn-1:0][2:0]                        wait_q;     // grants lost while requesting

  always_comb begin
    for (int i = 0; i < tcdm_pkg::NumIn; i++) begin
      sel[i] = tcdm_req_i[i].addr[tcdm_pkg::ByteOffWidth +: tcdm_pkg::BankSelWidth];
      for (int b = 0; b < tcdm_pkg::NumBanks; b++) begin
        bank_gnt[b][i]  = gnt_i[i] && (sel[i] == tcdm_pkg::BankSelWidth'(b));
        busy_bank[b][i] = (inflight_q[i] != '0) && (last_bank_q[i] == tcdm_pkg::BankSelWidth'(b));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q  <= '0;
      last_bank_q <= '0;
      wait_q      <= '0;
    end else begin
      for (int i = 0; i < tcdm_pkg::NumIn; i++) begin
        inflight_q[i] <= inflight_q[i] + 2'(gnt_i[i]) - 2'(vld_i[i] & rdy_i[i]);
        if (gnt_i[i]) last_bank_q[i] <= sel[i];
        if (!req_i[i] || gnt_i[i]) wait_q[i] <= '0;
        else if (|bank_gnt[sel[i]]) wait_q[i] <= wait_q[i] + 1'b1;  // another one won the bank
      end
    end
  end

  default disable iff (!rst_ni);

  for (genvar i = 0; i < tcdm_pkg::NumIn; i++) begin : gen_initiator
    assert property (@(posedge clk_i) vld_i[i] && rdy_i[i] && tcdm_subsys_tb.pend_load[i]
                     |-> rdata_i[i] == tcdm_subsys_tb.exp_rdata[i])
      else $error("CHECK FAILED at %0t: initiator %0d load returned %h, expected %h (error %0d)",
                  $time, i, $sampled(rdata_i[i]), $sampled(tcdm_subsys_tb.exp_rdata[i]),
                  tcdm_subsys_tb.count_error(1'b1));
    assert property (@(posedge clk_i) gnt_i[i] && tcdm_req_i[i].wen |-> ##[1:48] vld_i[i] && rdy_i[i])
      else $error("initiator %0d got no response to a granted store (error %0d)", i,
                  tcdm_subsys_tb.count_error(1'b0));
    assert property (@(posedge clk_i) vld_i[i] && !rdy_i[i]
                     |=> vld_i[i] && (rdata_i[i] === $past(rdata_i[i])))
      else $error("initiator %0d response changed while stalled (error %0d)", i,
                  tcdm_subsys_tb.count_error(1'b0));
    assert property (@(posedge clk_i) gnt_i[i] |-> req_i[i])
      else $error("initiator %0d granted without a request (error %0d)", i,
                  tcdm_subsys_tb.count_error(1'b0));
    assert property (@(posedge clk_i) vld_i[i] |-> inflight_q[i] != '0)
      else $error("initiator %0d got a response with nothing in flight (error %0d)", i,
                  tcdm_subsys_tb.count_error(1'b0));
    assert property (@(posedge clk_i) wait_q[i] < 3'(tcdm_pkg::NumIn))
      else $error("initiator %0d starved by round-robin arbiter (error %0d)", i,
                  tcdm_subsys_tb.count_error(1'b0));
  end

  for (genvar b = 0; b < tcdm_pkg::NumBanks; b++) begin : gen_bank
    assert property (@(posedge clk_i) $onehot0(bank_gnt[b]))
      else $error("bank %0d granted two initiators in one cycle (error %0d)", b,
                  tcdm_subsys_tb.count_error(1'b0));
    assert property (@(posedge clk_i) $countones(busy_bank[b]) <= tcdm_pkg::NumOutstanding)
      else $error("bank %0d holds too many transactions in flight (error %0d)", b,
                  tcdm_subsys_tb.count_error(1'b0));
  end

endmodule

`default_nettype wire

/* tcdm_subsys_tb.sv */
`default_nettype none

module tcdm_subsys_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic                                                clk = 1'b0;
  logic                                                rst_n;
  logic [tcdm_pkg::NumIn-1:0]                          req, gnt, vld, rdy;
  tcdm_pkg::tcdm_req_t [tcdm_pkg::NumIn-1:0]           tcdm_req;
  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::DataWidth-1:0] rdata;
  logic [tcdm_pkg::DataWidth-1:0]                      shadow [64];  // 16 words of every bank
  logic [63:0]                                         written;      // word holds known data
  logic [tcdm_pkg::NumIn-1:0]                          busy_q;       // granted and waiting for vld
  logic [tcdm_pkg::NumIn-1:0]                          pend_load;    // outstanding op is a load
  logic [tcdm_pkg::NumIn-1:0][tcdm_pkg::DataWidth-1:0] exp_rdata;
  int                                                  seed = 32'h757a_194e;
  int unsigned num_ops = 160;      // random phase over all initiators
  int unsigned stall_cycles = 24;  // ready held low in the contention phase
  int unsigned burst_ops = 16;     // back-to-back ops into bank 0 after the stall
  int unsigned issued, op_limit, cycle_cnt, max_cycles, value_errs, proto_errs;

  always #20 clk = ~clk;  // 40 ns period

  tcdm_subsys u_tcdm_subsys (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .req_i     (req),
    .tcdm_req_i(tcdm_req),
    .gnt_o     (gnt),
    .vld_o     (vld),
    .rdata_o   (rdata),
    .rdy_i     (rdy)
  );

  bind tcdm_subsys tcdm_subsys_properties u_properties (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .tcdm_req_i(tcdm_req_i),
    .gnt_i     (gnt_o),
    .vld_i     (vld_o),
    .rdata_i   (rdata_o),
    .rdy_i     (rdy_i)
  );

  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int j = 0; j < 4; j++) begin
      if (be[j]) res[8*j +: 8] = new_w[8*j +: 8];
    end
    return res;
  endfunction

  // bumps one error counter and returns the running total
  function automatic int unsigned count_error(input bit wrong_value);
    if (wrong_value) value_errs++;
    else proto_errs++;
    return value_errs + proto_errs;
  endfunction

  function automatic bit all_idle();
    return (req == '0) && (busy_q == '0);
  endfunction

  task automatic drive_initiators(input bit one_bank, input bit stall);
    logic [31:0] rnd;
    logic [5:0]  w;
    for (int i = 0; i < tcdm_pkg::NumIn; i++) begin
      rnd    = $random(seed);
      rdy[i] = stall ? 1'b0 : (rnd[1:0] != 2'b00);  // ready three cycles out of four
      if (busy_q[i]) begin
        req[i] = 1'b0;  // granted and waiting for vld
      end else if (!req[i] && issued < op_limit && rnd[2]) begin
        w = one_bank ? {rnd[8:5], 2'b00} : rnd[8:3];  // low two bits pick the bank
        req[i]            = 1'b1;
        tcdm_req[i].wen   = !written[w] || rnd[9];  // unknown words get written first
        tcdm_req[i].be    = written[w] ? rnd[13:10] : 4'hf;
        tcdm_req[i].addr  = {24'h0, w, 2'b00};
        tcdm_req[i].wdata = $random(seed);
        issued++;
      end
    end
  endtask

  // banks execute in grant order so the shadow memory follows it
  always @(posedge clk or negedge rst_n) begin : track
    logic [5:0] w;
    if (!rst_n) begin
      busy_q    <= '0;
      pend_load <= '0;
      exp_rdata <= '0;
    end else begin
      for (int i = 0; i < tcdm_pkg::NumIn; i++) begin
        w = tcdm_req[i].addr[7:2];
        if (req[i] && gnt[i]) begin
          busy_q[i]    <= 1'b1;
          pend_load[i] <= !tcdm_req[i].wen;
          exp_rdata[i] <= shadow[w];
          if (tcdm_req[i].wen) begin
            shadow[w]  = merge_bytes(shadow[w], tcdm_req[i].wdata, tcdm_req[i].be);
            written[w] = 1'b1;
          end
        end else if (vld[i] && rdy[i]) begin
          busy_q[i] <= 1'b0;
        end
      end
    end
  end

  initial begin : stimulus
    rst_n      = 1'b0;
    req        = '0;
    rdy        = '0;
    tcdm_req   = '0;
    written    = '0;
    issued     = 0;
    value_errs = 0;
    proto_errs = 0;
    op_limit   = num_ops;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    do begin  // random traffic over all banks
      @(negedge clk);
      drive_initiators(1'b0, 1'b0);
    end while (issued < op_limit || !all_idle());
    op_limit = issued + burst_ops;  // all initiators keep contending for bank 0
    repeat (stall_cycles) begin
      @(negedge clk);
      drive_initiators(1'b1, 1'b1);  // back-pressure fills the bank 0 queue
    end
    do begin
      @(negedge clk);
      drive_initiators(1'b1, 1'b0);
    end while (issued < op_limit || !all_idle());
    repeat (4) @(negedge clk);
    $display("checks failed: %0d wrong values, %0d protocol errors", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt  = 0;
    max_cycles = 2 * (8 + 2 * num_ops + stall_cycles + 3 * burst_ops);  // twice the planned run
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: traffic did not drain within %0d cycles", max_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tcdm_subsys.f */
tcdm_pkg.sv
tcdm_xbar.sv
tcdm_target_queue.sv
tcdm_interconnect.sv
tcdm_bank.sv
tcdm_subsys.sv
tcdm_subsys_properties.sv
tcdm_subsys_tb.sv

/* Bender.yml */
package:
  name: tcdm_subsys

sources:
  - tcdm_pkg.sv
  - tcdm_xbar.sv
  - tcdm_target_queue.sv
  - tcdm_interconnect.sv
  - tcdm_bank.sv
  - tcdm_subsys.sv
  - target: test
    files:
      - tcdm_subsys_properties.sv
      - tcdm_subsys_tb.sv
